/* accel/accel_wrap.sv */
`timescale 1ns/1ps
`include "accel_cfg.svh"

module accel_wrap
  import host_io_pkg::*;
  import regex_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  input  host_req_t                  host,
  output logic [`ACC_DATA_WIDTH-1:0] rd_data,

  output acc_cmd_t                   cmd,
  output logic                       cmd_valid,
  input  logic                       acc_ready,
  input  acc_status_t                status,

  output mem_port_t                  mem_a,
  input  logic [`ACC_DATA_WIDTH-1:0] mem_a_rd_data
);

  logic [`ACC_LEN_WIDTH-1:0]  cmd_addr_q;
  logic [`ACC_LEN_WIDTH-1:0]  cmd_len_q;
  logic                       cmd_valid_q;
  logic                       win_page_q;
  logic                       rd_win_q;
  logic [`ACC_DATA_WIDTH-1:0] reg_rd_q;
  logic                       reg_sel;
  logic                       win_sel;

  assign reg_sel = !host.addr[9] && (host.addr[8:4] == 5'd0);
  assign win_sel = host.addr[9];

  assign cmd.addr  = cmd_addr_q;
  assign cmd.len   = cmd_len_q;
  assign cmd_valid = cmd_valid_q;

  // window half 0 or 1 is picked by the page bit, the address picks the line
  always_comb begin
    mem_a.en      = win_sel && (host.read || host.write);
    mem_a.wen     = (win_sel && host.write) ? host.strb : '0;
    mem_a.addr    = {win_page_q, host.addr[8:4]};
    mem_a.wr_data = host.wr_data;
  end

  // both paths line up one cycle after the read strobe
  assign rd_data = rd_win_q ? mem_a_rd_data : reg_rd_q;

  always_ff @(posedge clk) begin
    cmd_valid_q <= cmd_valid_q && !acc_ready;

    if (host.write && reg_sel) begin
      if (host.strb[0] && host.wr_data[0] && !status.busy) begin
        cmd_valid_q <= 1'b1;  // a start while busy is dropped
      end
      if (host.strb[2]) begin
        win_page_q <= host.wr_data[16];
      end
      if (|host.strb[7:4]) begin
        cmd_len_q <= host.wr_data[47:32];
      end
      if (|host.strb[15:8]) begin
        cmd_addr_q <= host.wr_data[79:64];
      end
    end

    if (host.read) begin
      rd_win_q <= win_sel;
      reg_rd_q <= '0;
      if (reg_sel) begin
        reg_rd_q[0]     <= cmd_valid_q;
        reg_rd_q[1]     <= acc_ready;
        reg_rd_q[8]     <= status.done;
        reg_rd_q[9]     <= status.match;
        reg_rd_q[16]    <= win_page_q;
        reg_rd_q[47:32] <= cmd_len_q;
        reg_rd_q[79:64] <= cmd_addr_q;
      end
    end

    if (rst) begin
      cmd_valid_q <= 1'b0;
      win_page_q  <= 1'b0;
      rd_win_q    <= 1'b0;
    end
  end

endmodule

/* common/accel_cfg.svh */
`ifndef ACCEL_CFG_SVH
`define ACCEL_CFG_SVH

// host bus and memory line geometry
`define ACC_DATA_WIDTH      128
`define ACC_STRB_WIDTH      16
`define ACC_IO_ADDR_WIDTH   10
`define ACC_MEM_LINES       64
`define ACC_LINE_ADDR_WIDTH 6

// command fields and flow control
`define ACC_LEN_WIDTH       16
`define ACC_CREDITS         4

// fixed expression ab+c
`define ACC_PAT_A           8'h61
`define ACC_PAT_B           8'h62
`define ACC_PAT_C           8'h63

`endif

/* common/host_io_pkg.sv */
`include "accel_cfg.svh"

package host_io_pkg;

  // one cycle on the host register bus
  typedef struct packed {
    logic [`ACC_IO_ADDR_WIDTH-1:0] addr;
    logic [`ACC_STRB_WIDTH-1:0]    strb;
    logic                          write;
    logic                          read;
    logic [`ACC_DATA_WIDTH-1:0]    wr_data;
  } host_req_t;

  // addr is a byte address into the scratch memory
  typedef struct packed {
    logic [`ACC_LEN_WIDTH-1:0] addr;
    logic [`ACC_LEN_WIDTH-1:0] len;
  } acc_cmd_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic match;
  } acc_status_t;

endpackage

/* common/regex_pkg.sv */
`include "accel_cfg.svh"

package regex_pkg;

  // one access on a scratch memory port where wen is a byte strobe
  typedef struct packed {
    logic                            en;
    logic [`ACC_STRB_WIDTH-1:0]      wen;
    logic [`ACC_LINE_ADDR_WIDTH-1:0] addr;
    logic [`ACC_DATA_WIDTH-1:0]      wr_data;
  } mem_port_t;

  // a memory line with the byte range that belongs to the slice
  typedef struct packed {
    logic [`ACC_DATA_WIDTH-1:0] data;
    logic [3:0]                 first_idx;
    logic [3:0]                 last_idx;
    logic                       last;       // final line of the slice
  } line_beat_t;

  typedef enum logic [1:0] {
    dfa_idle  = 2'd0,
    dfa_saw_a = 2'd1,
    dfa_saw_b = 2'd2,
    dfa_found = 2'd3
  } dfa_state_t;

endpackage

/* hdl/acc_mem.sv */
`timescale 1ns/1ps
`include "accel_cfg.svh"

module acc_mem
  import regex_pkg::*;
(
  input  logic                       clk,

  input  mem_port_t                  a,
  output logic [`ACC_DATA_WIDTH-1:0] a_rd_data,

  input  mem_port_t                  b,
  output logic [`ACC_DATA_WIDTH-1:0] b_rd_data
);

  logic [`ACC_DATA_WIDTH-1:0] mem_q [`ACC_MEM_LINES];
  logic [`ACC_DATA_WIDTH-1:0] a_rd_q;
  logic [`ACC_DATA_WIDTH-1:0] b_rd_q;

  // the host port read returns the old line when that line is written in the same cycle
  always_ff @(posedge clk) begin
    if (a.en) begin
      a_rd_q <= mem_q[a.addr];
      for (int i = 0; i < `ACC_STRB_WIDTH; i++) begin
        if (a.wen[i]) begin
          mem_q[a.addr][i*8 +: 8] <= a.wr_data[i*8 +: 8];
        end
      end
    end
  end

  // accelerator port is read only
  always_ff @(posedge clk) begin
    if (b.en) begin
      b_rd_q <= mem_q[b.addr];
    end
  end

  assign a_rd_data = a_rd_q;
  assign b_rd_data = b_rd_q;

endmodule

/* hdl/regex_top.sv */
`timescale 1ns/1ps
`include "accel_cfg.svh"

module regex_top
  import host_io_pkg::*;
  import regex_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  host_req_t                  host,
  output logic [`ACC_DATA_WIDTH-1:0] rd_data
);

  acc_cmd_t                   cmd;
  logic                       cmd_valid;
  logic                       acc_ready;
  acc_status_t                status;
  mem_port_t                  mem_a;
  mem_port_t                  mem_b;
  logic [`ACC_DATA_WIDTH-1:0] mem_a_rd_data;
  logic [`ACC_DATA_WIDTH-1:0] mem_b_rd_data;

  accel_wrap accel_wrap_i (
    .clk(clk),
    .rst(rst),
    .host(host),
    .rd_data(rd_data),
    .cmd(cmd),
    .cmd_valid(cmd_valid),
    .acc_ready(acc_ready),
    .status(status),
    .mem_a(mem_a),
    .mem_a_rd_data(mem_a_rd_data)
  );

  regex_acc regex_acc_i (
    .clk(clk),
    .rst(rst),
    .cmd(cmd),
    .cmd_valid(cmd_valid),
    .acc_ready(acc_ready),
    .status(status),
    .mem_b(mem_b),
    .mem_b_rd_data(mem_b_rd_data)
  );

  acc_mem acc_mem_i (
    .clk(clk),
    .a(mem_a),
    .a_rd_data(mem_a_rd_data),
    .b(mem_b),
    .b_rd_data(mem_b_rd_data)
  );

endmodule

/* regex/regex_acc.sv */
`timescale 1ns/1ps
`include "accel_cfg.svh"

module regex_acc
  import host_io_pkg::*;
  import regex_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  input  acc_cmd_t                   cmd,
  input  logic                       cmd_valid,
  output logic                       acc_ready,
  output acc_status_t                status,

  output mem_port_t                  mem_b,
  input  logic [`ACC_DATA_WIDTH-1:0] mem_b_rd_data
);

  line_beat_t beat;
  logic       beat_valid;
  logic       credit_return;
  logic       slice_end;
  logic       found;

  logic       busy_q;
  logic       done_q;
  logic       match_q;
  logic       accept;
  logic       start_run;

  assign acc_ready = !busy_q;
  assign accept    = cmd_valid && acc_ready;
  assign start_run = accept && (cmd.len != '0);  // an empty slice never runs

  always_ff @(posedge clk) begin
    if (accept) begin
      busy_q  <= start_run;
      done_q  <= !start_run;
      match_q <= 1'b0;
    end

    if (slice_end) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b1;
      match_q <= found;
    end

    if (rst) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      match_q <= 1'b0;
    end
  end

  assign status.busy  = busy_q;
  assign status.done  = done_q;
  assign status.match = match_q;

  regex_fetch regex_fetch_i (
    .clk(clk),
    .rst(rst),
    .start(start_run),
    .cmd(cmd),
    .mem_b(mem_b),
    .mem_b_rd_data(mem_b_rd_data),
    .beat(beat),
    .beat_valid(beat_valid),
    .credit_return(credit_return)
  );

  regex_match regex_match_i (
    .clk(clk),
    .rst(rst),
    .start(start_run),
    .beat(beat),
    .beat_valid(beat_valid),
    .credit_return(credit_return),
    .slice_end(slice_end),
    .found(found)
  );

endmodule

/* regex/regex_fetch.sv */
`timescale 1ns/1ps
`include "accel_cfg.svh"

module regex_fetch
  import host_io_pkg::*;
  import regex_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       start,
  input  acc_cmd_t                   cmd,

  output mem_port_t                  mem_b,
  input  logic [`ACC_DATA_WIDTH-1:0] mem_b_rd_data,

  output line_beat_t                 beat,
  output logic                       beat_valid,
  input  logic                       credit_return
);

  localparam int LINE_W = `ACC_LEN_WIDTH - 4;
  localparam int CRED_W = $clog2(`ACC_CREDITS + 1);

  logic [`ACC_LEN_WIDTH-1:0] end_addr;
  logic [LINE_W-1:0]         line_q;
  logic [LINE_W-1:0]         last_line_q;
  logic [3:0]                first_idx_q;
  logic [3:0]                end_idx_q;
  logic                      active_q;
  logic                      first_line_q;
  logic [CRED_W-1:0]         credits_q;
  logic                      issue;
  logic                      at_last;

  logic                      pend_q;
  logic [3:0]                pend_first_q;
  logic [3:0]                pend_last_idx_q;
  logic                      pend_last_q;

  assign end_addr = cmd.addr + cmd.len - 1'b1;
  assign issue    = active_q && (credits_q != '0);  // a read spends its credit up front
  assign at_last  = (line_q == last_line_q);

  always_comb begin
    mem_b.en      = issue;
    mem_b.wen     = '0;
    mem_b.addr    = line_q[`ACC_LINE_ADDR_WIDTH-1:0];
    mem_b.wr_data = '0;
  end

  // the line arrives a cycle after its read, tagged with the range taken then
  always_comb begin
    beat.data      = mem_b_rd_data;
    beat.first_idx = pend_first_q;
    beat.last_idx  = pend_last_idx_q;
    beat.last      = pend_last_q;
  end
  assign beat_valid = pend_q;

  always_ff @(posedge clk) begin
    pend_q <= issue;

    if (start) begin
      line_q       <= cmd.addr[`ACC_LEN_WIDTH-1:4];
      last_line_q  <= end_addr[`ACC_LEN_WIDTH-1:4];
      first_idx_q  <= cmd.addr[3:0];
      end_idx_q    <= end_addr[3:0];
      first_line_q <= 1'b1;
      active_q     <= 1'b1;
    end

    if (issue) begin
      line_q          <= line_q + 1'b1;
      first_line_q    <= 1'b0;
      pend_first_q    <= first_line_q ? first_idx_q : 4'd0;
      pend_last_idx_q <= at_last ? end_idx_q : 4'hf;
      pend_last_q     <= at_last;
      if (at_last) begin
        active_q <= 1'b0;
      end
    end

    case ({issue, credit_return})
      2'b10:   credits_q <= credits_q - 1'b1;
      2'b01:   credits_q <= credits_q + 1'b1;
      default: credits_q <= credits_q;
    endcase

    if (rst) begin
      active_q  <= 1'b0;
      pend_q    <= 1'b0;
      credits_q <= CRED_W'(`ACC_CREDITS);
    end
  end

endmodule

/* regex/regex_match.sv */
`timescale 1ns/1ps
`include "accel_cfg.svh"

module regex_match
  import regex_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       start,
  input  line_beat_t beat,
  input  logic       beat_valid,

  output logic       credit_return,
  output logic       slice_end,
  output logic       found
);

  localparam int PTR_W = $clog2(`ACC_CREDITS);

  line_beat_t  slot_q [`ACC_CREDITS];
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;
  logic [3:0]  byte_idx_q;
  logic        in_line_q;
  dfa_state_t  state_q;
  dfa_state_t  state_next;
  line_beat_t  cur;
  logic [3:0]  byte_sel;
  logic [7:0]  cur_byte;
  logic        have_line;
  logic        line_done;
  logic        credit_q;
  logic        slice_end_q;

  // extra pointer bit tells full from empty, credits keep it from filling past depth
  assign have_line = (wr_ptr_q != rd_ptr_q);
  assign cur       = slot_q[rd_ptr_q[PTR_W-1:0]];
  assign byte_sel  = in_line_q ? byte_idx_q : cur.first_idx;
  assign cur_byte  = cur.data[{byte_sel, 3'b000} +: 8];
  assign line_done = have_line && (byte_sel == cur.last_idx);

  always_comb begin
    state_next = dfa_idle;
    if (state_q == dfa_found) begin
      state_next = dfa_found;
    end else if (cur_byte == `ACC_PAT_A) begin
      state_next = dfa_saw_a;
    end else if (cur_byte == `ACC_PAT_B && state_q != dfa_idle) begin
      state_next = dfa_saw_b;
    end else if (cur_byte == `ACC_PAT_C && state_q == dfa_saw_b) begin
      state_next = dfa_found;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid) begin
      slot_q[wr_ptr_q[PTR_W-1:0]] <= beat;
    end
  end

  always_ff @(posedge clk) begin
    credit_q    <= line_done;
    slice_end_q <= line_done && cur.last;

    if (beat_valid) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end

    if (have_line) begin
      state_q <= state_next;  // one byte per cycle
      if (line_done) begin
        rd_ptr_q  <= rd_ptr_q + 1'b1;
        in_line_q <= 1'b0;
      end else begin
        byte_idx_q <= byte_sel + 1'b1;
        in_line_q  <= 1'b1;
      end
    end

    if (start) begin
      state_q <= dfa_idle;
    end

    if (rst) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      in_line_q   <= 1'b0;
      state_q     <= dfa_idle;
      credit_q    <= 1'b0;
      slice_end_q <= 1'b0;
    end
  end

  assign credit_return = credit_q;
  assign slice_end     = slice_end_q;
  assign found         = (state_q == dfa_found);

endmodule

/* tests/regex_stimulus.txt */
# fields in hex: T test | W line strb data | R line data | F line count | S addr len
# L addr len | K ready done match | C addr len | E done match | X ends the test
T 1
K 1 0 0
S 0045 0123
L 0045 0123
X
T 2
W 05 ffff 00112233445566778899aabbccddeeff
W 05 00f0 00000000000000000000000000000000
R 05 001122334455667700000000ccddeeff
W 2a ffff 0f0e0d0c0b0a09080706050403020100
W 2a 8001 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
R 2a a50e0d0c0b0a090807060504030201a5
R 05 001122334455667700000000ccddeeff
X
# abbbc in line 0, ac in line 1, abxc in line 2
T 3
F 00 03
W 00 03e0 00000000000063626262610000000000
W 01 000c 00000000000000000000000063610000
W 02 0f00 00000000637862610000000000000000
C 0003 000a
E 1 1
C 0010 0010
E 1 0
C 0020 0010
E 1 0
X
# abbc from byte 0x8e to byte 0x91, across the line boundary
T 4
F 08 02
W 08 c000 62610000000000000000000000000000
W 09 0003 00000000000000000000000000006362
C 008c 0008
E 1 1
C 008f 0008
E 1 0
C 008c 0005
E 1 0
X
T 5
F 10 30
W 3f 0070 00000000000000000063626100000000
C 0100 0300
E 1 1
X
# the second command arrives while the first is busy
T 6
C 0100 0300
C 0010 0010
E 1 1
L 0010 0010
C 0020 0010
E 1 0
C 0000 0010
E 1 1
K 1 1 1
X

/* tests/tb_regex_top.sv */
`timescale 1ns/1ps
`include "accel_cfg.svh"

module tb_regex_top
  import host_io_pkg::*;
();

  localparam int    CLK_HALF   = 20;
  localparam int    RST_CYCLES = 5;
  localparam string STIM_FILE  = "tests/regex_stimulus.txt";

  logic                       clk;
  logic                       rst;
  host_req_t                  host;
  logic [`ACC_DATA_WIDTH-1:0] rd_data;

  integer seed;
  int     cycles;
  int     cycle_limit;
  int     max_len;
  int     errors;  // counts only the test that is running
  int     all_errors;
  int     bad_lines;
  int     tests_passed;
  int     tests_failed;
  logic   cur_page;

  regex_top regex_top_i (
    .clk(clk),
    .rst(rst),
    .host(host),
    .rd_data(rd_data)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout, the run went past %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic note_error();
    errors++;
    all_errors++;
  endtask

  task automatic flag_mismatch(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
    $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    note_error();
  endtask

  task automatic host_write(input logic [9:0] addr, input logic [15:0] strb,
                            input logic [127:0] data);
    host_req_t req;
    req         = '0;
    req.addr    = addr;
    req.strb    = strb;
    req.write   = 1'b1;
    req.wr_data = data;
    @(posedge clk);
    host <= req;
    @(posedge clk);
    host <= '0;
  endtask

  // read data is registered and is taken half a cycle after the DUT saw the read
  task automatic host_read(input logic [9:0] addr, output logic [127:0] data);
    host_req_t req;
    req      = '0;
    req.addr = addr;
    req.read = 1'b1;
    @(posedge clk);
    host <= req;
    @(posedge clk);
    host <= '0;
    @(negedge clk);
    data = rd_data;
  endtask

  // the window shows 32 lines and bit 16 of the command word picks the half
  task automatic select_page(input logic [5:0] mem_line);
    logic [127:0] data;
    data     = '0;
    data[16] = mem_line[5];
    if (mem_line[5] != cur_page) begin
      host_write(10'h000, 16'h0004, data);
      cur_page = mem_line[5];
    end
  endtask

  function automatic logic [9:0] window_addr(input logic [5:0] mem_line);
    return {1'b1, mem_line[4:0], 4'h0};
  endfunction

  task automatic window_write(input logic [5:0] mem_line, input logic [15:0] strb,
                              input logic [127:0] data);
    select_page(mem_line);
    host_write(window_addr(mem_line), strb, data);
  endtask

  task automatic window_check(input logic [5:0] mem_line, input logic [127:0] exp);
    logic [127:0] got;
    select_page(mem_line);
    host_read(window_addr(mem_line), got);
    assert (got === exp) else flag_mismatch($sformatf("window line %0h", mem_line), got, exp);
  endtask

  // filler letters run from d to z, so they never take part in a match
  task automatic fill_lines(input logic [5:0] first, input int count);
    logic [127:0] data;
    logic [5:0]   mem_line;
    integer       r;
    logic [31:0]  pick;
    mem_line = first;
    for (int l = 0; l < count; l++) begin
      for (int b = 0; b < 16; b++) begin
        r    = $random(seed);
        pick = (r & 32'h7fffffff) % 23;
        data[b*8 +: 8] = 8'h64 + pick[7:0];
      end
      window_write(mem_line, 16'hffff, data);
      mem_line = mem_line + 1'b1;
    end
  endtask

  task automatic write_cmd(input logic [15:0] addr, input logic [15:0] len,
                           input logic start);
    logic [127:0] data;
    data        = '0;
    data[0]     = start;
    data[47:32] = len;
    data[79:64] = addr;
    host_write(10'h000, start ? 16'hfff1 : 16'hfff0, data);
  endtask

  task automatic check_cmd_fields(input logic [15:0] addr, input logic [15:0] len);
    logic [127:0] word;
    host_read(10'h000, word);
    assert (word[79:64] === addr) else flag_mismatch("command addr", word[79:64], addr);
    assert (word[47:32] === len) else flag_mismatch("command len", word[47:32], len);
  endtask

  task automatic check_status(input logic ready, input logic done, input logic match);
    logic [127:0] word;
    host_read(10'h000, word);
    assert (word[1] === ready) else flag_mismatch("ready", word[1], ready);
    assert (word[8] === done) else flag_mismatch("done", word[8], done);
    assert (word[9] === match) else flag_mismatch("match", word[9], match);
  endtask

  // match was cleared at acceptance, so it has to stay low until done rises
  task automatic wait_done(input logic exp_match);
    logic [127:0] word;
    int           polls;
    word  = '0;
    polls = 0;
    while (word[8] !== 1'b1 && polls < max_len + 50) begin
      host_read(10'h000, word);
      polls++;
      if (word[8] !== 1'b1) begin
        assert (word[9] === 1'b0) else flag_mismatch("match before done", word[9], 1'b0);
      end
    end
    if (word[8] !== 1'b1) begin
      $display("done never rose after %0d status reads", polls);
      note_error();
    end else begin
      assert (word[9] === exp_match) else flag_mismatch("match", word[9], exp_match);
    end
  endtask

  function automatic int field_count(input logic [7:0] kind);
    case (kind)
      "T":                          return 1;
      "R", "F", "S", "L", "C", "E": return 2;
      "W", "K":                     return 3;
      "X":                          return 0;
      default:                      return -1;
    endcase
  endfunction

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  // the run limit grows with the command lengths in the file
  task automatic scan_lengths(output int total);
    int           fd;
    int           code;
    logic [7:0]   kind;
    logic [127:0] addr;
    logic [127:0] len;
    total   = 0;
    max_len = 0;
    fd      = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        if (kind == "C") begin
          code = $fscanf(fd, "%h %h", addr, len);
          if (code == 2) begin
            total = total + len[15:0];
            if (len[15:0] > max_len) begin
              max_len = len[15:0];
            end
          end
        end
        skip_line(fd);
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int           fd;
    int           code;
    int           want;
    int           total_len;
    int           test_num;
    logic [7:0]   kind;
    logic [127:0] f0;
    logic [127:0] f1;
    logic [127:0] f2;

    clk          = 1'b0;
    rst          = 1'b1;
    host         = '0;
    seed         = 32'h2d1;
    cycles       = 0;
    cycle_limit  = 0;
    errors       = 0;
    all_errors   = 0;
    bad_lines    = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_num     = 0;
    cur_page     = 1'b0;  // page bit comes out of reset as 0

    scan_lengths(total_len);
    cycle_limit = total_len * 4 + 2000;

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      bad_lines++;
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        if (kind == "#") begin
          skip_line(fd);
        end else begin
          want = field_count(kind);
          code = 0;
          f0   = '0;
          f1   = '0;
          f2   = '0;
          if (want == 1) begin
            code = $fscanf(fd, "%h", f0);
          end else if (want == 2) begin
            code = $fscanf(fd, "%h %h", f0, f1);
          end else if (want == 3) begin
            code = $fscanf(fd, "%h %h %h", f0, f1, f2);
          end
          if (want < 0 || code != want) begin
            $display("stimulus line of kind %c could not be read", kind);
            bad_lines++;
            skip_line(fd);
          end else begin
            case (kind)
              "T": begin
                test_num = f0[31:0];
                errors   = 0;
              end
              "W": window_write(f0[5:0], f1[15:0], f2);
              "R": window_check(f0[5:0], f1);
              "F": fill_lines(f0[5:0], f1[7:0]);
              "S": write_cmd(f0[15:0], f1[15:0], 1'b0);
              "L": check_cmd_fields(f0[15:0], f1[15:0]);
              "K": check_status(f0[0], f1[0], f2[0]);
              "C": write_cmd(f0[15:0], f1[15:0], 1'b1);
              "E": wait_done(f1[0]);
              "X": begin
                if (errors == 0) begin
                  $display("test %0d: no errors", test_num);
                  tests_passed++;
                end else begin
                  $display("test %0d: %0d errors", test_num, errors);
                  tests_failed++;
                end
              end
              default: bad_lines++;
            endcase
          end
        end
      end
      $fclose(fd);
    end

    $display("tests passing: %0d, tests failing: %0d", tests_passed, tests_failed);
    if (all_errors == 0 && bad_lines == 0 && tests_passed > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/host_io_pkg.sv
common/regex_pkg.sv
hdl/acc_mem.sv
accel/accel_wrap.sv
regex/regex_fetch.sv
regex/regex_match.sv
regex/regex_acc.sv
hdl/regex_top.sv
tests/tb_regex_top.sv
